// ==== include/branch_config.svh ====
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// Width of an integer or floating-point operand
`define BR_XLEN 32
// Width of the program counter
`define BR_PC_W 32
// Size of one instruction in bytes; also the displacement scale
`define BR_INSN_BYTES 4

`endif

// ==== verilog/branch_pkg.sv ====
`default_nettype none

`include "branch_config.svh"

package branch_pkg;

	// ==============================
	// Opcodes
	// ==============================

	// Only the two branch opcodes are named here
	// Every other encoding is treated as a non-branch by the unit
	typedef enum logic [6:0] {
		OP_BCC  = 7'h28,
		OP_FBCC = 7'h29
	} opcode_t;

	// ==============================
	// Instruction and operands
	// ==============================

	// Branch instruction word, opcode sits in the low bits
	// The displacement counts instructions, not bytes
	typedef struct packed {
		logic [16:0] disp;
		logic [4:0]  rb;
		logic [2:0]  cnd;
		opcode_t     opcode;
	} instruction_t;

	// One register operand
	typedef logic [`BR_XLEN-1:0] value_t;

	// ==============================
	// Floating-point compare result
	// ==============================

	// Ordered relations are all low when unord is set
	typedef struct packed {
		logic eq;
		logic lt;
		logic le;
		logic unord;
	} fp_flags_t;

endpackage

`default_nettype wire

// ==== verilog/fp_compare.sv ====
`default_nettype none

module fp_compare (
	input  branch_pkg::value_t    a_i,
	input  branch_pkg::value_t    b_i,
	output branch_pkg::fp_flags_t flags_o
);

	// IEEE-754 single-precision field layout
	localparam int unsigned SIGN_BIT = 31;
	localparam int unsigned EXP_MSB  = 30;
	localparam int unsigned EXP_LSB  = 23;
	localparam int unsigned MAN_MSB  = 22;

	logic        a_sign;
	logic        b_sign;
	logic [30:0] a_mag;
	logic [30:0] b_mag;
	logic        a_nan;
	logic        b_nan;
	logic        unord;
	logic        both_zero;
	logic        eq_raw;
	logic        lt_raw;

	assign a_sign = a_i[SIGN_BIT];
	assign b_sign = b_i[SIGN_BIT];

	// Exponent and mantissa together order non-negative values like integers
	assign a_mag = a_i[EXP_MSB:0];
	assign b_mag = b_i[EXP_MSB:0];

	// A NaN has an all-ones exponent and a non-zero mantissa
	// Quiet and signalling NaNs are not told apart
	assign a_nan = (&a_i[EXP_MSB:EXP_LSB]) && (|a_i[MAN_MSB:0]);
	assign b_nan = (&b_i[EXP_MSB:EXP_LSB]) && (|b_i[MAN_MSB:0]);
	assign unord = a_nan | b_nan;

	// Plus and minus zero compare equal whatever their signs
	assign both_zero = (a_mag == '0) && (b_mag == '0);
	assign eq_raw    = both_zero || (a_i == b_i);

	// Order by sign first, then by magnitude
	// For two negatives the larger magnitude is the smaller value
	always_comb begin
		if (both_zero) begin
			lt_raw = 1'b0;
		end else if (a_sign != b_sign) begin
			lt_raw = a_sign;
		end else if (a_sign) begin
			lt_raw = a_mag > b_mag;
		end else begin
			lt_raw = a_mag < b_mag;
		end
	end

	// An unordered pair forces every ordered relation low
	assign flags_o.unord = unord;
	assign flags_o.eq    = ~unord & eq_raw;
	assign flags_o.lt    = ~unord & lt_raw;
	assign flags_o.le    = ~unord & (lt_raw | eq_raw);

endmodule

`default_nettype wire

// ==== verilog/branch_cond_eval.sv ====
`default_nettype none

module branch_cond_eval (
	input  branch_pkg::instruction_t ir_i,
	input  branch_pkg::value_t       a_i,
	input  branch_pkg::value_t       b_i,
	output logic                     taken_o
);

	import branch_pkg::*;

	fp_flags_t fp_flags;
	logic      int_taken;
	logic      fp_taken;

	fp_compare u_fp_compare (
		.a_i     (a_i),
		.b_i     (b_i),
		.flags_o (fp_flags)
	);

	// ==============================
	// Integer conditions
	// ==============================

	always_comb begin
		case (ir_i.cnd)
			3'd0: int_taken = $signed(a_i) < $signed(b_i);
			3'd1: int_taken = $signed(a_i) >= $signed(b_i);
			3'd2: int_taken = a_i < b_i;
			3'd3: int_taken = a_i >= b_i;
			// Bit test on operand a, b is not used
			3'd4: int_taken = a_i[ir_i.rb];
			3'd5: int_taken = 1'b0;
			3'd6: int_taken = a_i == b_i;
			default: int_taken = a_i != b_i;
		endcase
	end

	// ==============================
	// Floating-point conditions
	// ==============================

	always_comb begin
		case (ir_i.cnd)
			3'd0: fp_taken = fp_flags.eq;
			// Not-equal also holds for an unordered pair, eq is low then
			3'd1: fp_taken = ~fp_flags.eq;
			3'd2: fp_taken = fp_flags.lt;
			3'd3: fp_taken = fp_flags.le;
			3'd6: fp_taken = fp_flags.unord;
			3'd7: fp_taken = ~fp_flags.unord;
			// Codes 4 and 5 are reserved and never branch
			default: fp_taken = 1'b0;
		endcase
	end

	// Opcode decides which condition set applies
	always_comb begin
		case (ir_i.opcode)
			OP_BCC: taken_o = int_taken;
			OP_FBCC: taken_o = fp_taken;
			default: taken_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/branch_target_gen.sv ====
`default_nettype none

`include "branch_config.svh"

module branch_target_gen (
	input  logic [`BR_PC_W-1:0] pc_i,
	input  logic [16:0]         disp_i,
	output logic [`BR_PC_W-1:0] target_pc_o,
	output logic [`BR_PC_W-1:0] fallthrough_pc_o
);

	// Shift that turns an instruction count into a byte offset
	localparam int unsigned SCALE_SH = $clog2(`BR_INSN_BYTES);

	logic [`BR_PC_W-1:0] disp_ext;
	logic [`BR_PC_W-1:0] disp_bytes;

	// Sign-extend the word displacement to the full PC width
	assign disp_ext   = {{(`BR_PC_W-17){disp_i[16]}}, disp_i};
	assign disp_bytes = disp_ext << SCALE_SH;

	// Both adders run every cycle, the control picks one later
	assign target_pc_o      = pc_i + disp_bytes;
	assign fallthrough_pc_o = pc_i + `BR_PC_W'(`BR_INSN_BYTES);

endmodule

`default_nettype wire

// ==== verilog/branch_ctrl.sv ====
`default_nettype none

`include "branch_config.svh"

module branch_ctrl (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     hold_i,
	input  logic                     valid_i,
	input  branch_pkg::instruction_t ir_i,
	input  logic [`BR_PC_W-1:0]      pc_i,
	input  branch_pkg::value_t       a_i,
	input  branch_pkg::value_t       b_i,
	input  logic                     pred_taken_i,
	output branch_pkg::instruction_t s1_ir_o,
	output logic [`BR_PC_W-1:0]      s1_pc_o,
	output branch_pkg::value_t       s1_a_o,
	output branch_pkg::value_t       s1_b_o,
	input  logic                     cond_taken_i,
	input  logic [`BR_PC_W-1:0]      target_pc_i,
	input  logic [`BR_PC_W-1:0]      fallthrough_pc_i,
	output logic                     resolve_valid_o,
	output logic                     taken_o,
	output logic                     mispredict_o,
	output logic [`BR_PC_W-1:0]      redirect_pc_o
);

	import branch_pkg::*;

	logic                advance;

	// Issue stage
	logic                s1_valid;
	instruction_t        s1_ir;
	logic [`BR_PC_W-1:0] s1_pc;
	value_t              s1_a;
	value_t              s1_b;
	logic                s1_pred;

	// Result stage
	logic                s2_valid;
	logic                s2_taken;
	logic                s2_pred;
	logic [`BR_PC_W-1:0] s2_redirect;

	// Both stages move together, a hold freezes the whole pipe
	assign advance = ~hold_i;

	// ==============================
	// Stage valid bits
	// ==============================

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= valid_i;
			s2_valid <= s1_valid;
		end
	end

	// ==============================
	// Stage payload
	// ==============================

	// Payload only loads when a beat is present in the stage before
	always_ff @(posedge clk_i) begin
		if (advance && valid_i) begin
			s1_ir   <= ir_i;
			s1_pc   <= pc_i;
			s1_a    <= a_i;
			s1_b    <= b_i;
			s1_pred <= pred_taken_i;
		end
		// The redirect mux sits before the register to keep it off the output
		if (advance && s1_valid) begin
			s2_taken    <= cond_taken_i;
			s2_redirect <= cond_taken_i ? target_pc_i : fallthrough_pc_i;
			s2_pred     <= s1_pred;
		end
	end

	assign s1_ir_o = s1_ir;
	assign s1_pc_o = s1_pc;
	assign s1_a_o  = s1_a;
	assign s1_b_o  = s1_b;

	// Fetch only acts on a mispredict that belongs to a live beat
	assign resolve_valid_o = s2_valid;
	assign taken_o         = s2_taken;
	assign redirect_pc_o   = s2_redirect;
	assign mispredict_o    = s2_valid & (s2_taken ^ s2_pred);

	a_valid_known: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!$isunknown(resolve_valid_o)
	);

	// A held cycle leaves every output as it was, payload only matters with a beat
	a_hold_stable: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		hold_i |=> $stable({resolve_valid_o, mispredict_o}) &&
			(!resolve_valid_o || $stable({taken_o, redirect_pc_o}))
	);

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`default_nettype none

`include "branch_config.svh"

module branch_unit (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     hold_i,
	input  logic                     valid_i,
	input  branch_pkg::instruction_t ir_i,
	input  logic [`BR_PC_W-1:0]      pc_i,
	input  branch_pkg::value_t       a_i,
	input  branch_pkg::value_t       b_i,
	input  logic                     pred_taken_i,
	output logic                     resolve_valid_o,
	output logic                     taken_o,
	output logic                     mispredict_o,
	output logic [`BR_PC_W-1:0]      redirect_pc_o
);

	import branch_pkg::*;

	// Issue stage contents feeding the datapath
	instruction_t        s1_ir;
	logic [`BR_PC_W-1:0] s1_pc;
	value_t              s1_a;
	value_t              s1_b;

	// Datapath results going back into the control
	logic                cond_taken;
	logic [`BR_PC_W-1:0] target_pc;
	logic [`BR_PC_W-1:0] fallthrough_pc;

	branch_ctrl u_branch_ctrl (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.hold_i           (hold_i),
		.valid_i          (valid_i),
		.ir_i             (ir_i),
		.pc_i             (pc_i),
		.a_i              (a_i),
		.b_i              (b_i),
		.pred_taken_i     (pred_taken_i),
		.s1_ir_o          (s1_ir),
		.s1_pc_o          (s1_pc),
		.s1_a_o           (s1_a),
		.s1_b_o           (s1_b),
		.cond_taken_i     (cond_taken),
		.target_pc_i      (target_pc),
		.fallthrough_pc_i (fallthrough_pc),
		.resolve_valid_o  (resolve_valid_o),
		.taken_o          (taken_o),
		.mispredict_o     (mispredict_o),
		.redirect_pc_o    (redirect_pc_o)
	);

	branch_cond_eval u_branch_cond_eval (
		.ir_i    (s1_ir),
		.a_i     (s1_a),
		.b_i     (s1_b),
		.taken_o (cond_taken)
	);

	// Displacement comes straight out of the issued instruction
	branch_target_gen u_branch_target_gen (
		.pc_i             (s1_pc),
		.disp_i           (s1_ir.disp),
		.target_pc_o      (target_pc),
		.fallthrough_pc_o (fallthrough_pc)
	);

endmodule

`default_nettype wire

// ==== verif/branch_unit_tb.sv ====
`default_nettype none

`include "branch_config.svh"

module branch_unit_tb;

	import branch_pkg::*;

	// Beats issued over all tests: 52 integer, 96 float, 8 non-branch, 6 target, 2 hold
	localparam int TOTAL_BEATS = 164;
	localparam int CYCLE_LIMIT = 2 * TOTAL_BEATS + 100;

	logic                clk;
	logic                rst_n;
	logic                hold;
	logic                valid;
	instruction_t        ir;
	logic [`BR_PC_W-1:0] pc;
	value_t              a;
	value_t              b;
	logic                pred_taken;
	logic                resolve_valid;
	logic                taken;
	logic                mispredict;
	logic [`BR_PC_W-1:0] redirect_pc;

	// Expected results in issue order, packed as {taken, mispredict, redirect}
	logic [`BR_PC_W+1:0] expected_q[$];
	logic [`BR_PC_W+1:0] exp_result;
	// Count of advancing edges at which each queued result must be showing
	int                  due_q[$];
	int                  exp_due;
	int                  live_edges = 0;
	logic [31:0]         rng_state = 32'h543d_44da;
	int                  cycle_count = 0;
	int                  check_count = 0;
	int                  error_count = 0;

	branch_unit DUT (
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.hold_i          (hold),
		.valid_i         (valid),
		.ir_i            (ir),
		.pc_i            (pc),
		.a_i             (a),
		.b_i             (b),
		.pred_taken_i    (pred_taken),
		.resolve_valid_o (resolve_valid),
		.taken_o         (taken),
		.mispredict_o    (mispredict),
		.redirect_pc_o   (redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==============================
	// Reference model
	// ==============================

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic int_condition(input logic [2:0] cnd, input logic [4:0] rb,
			input logic [31:0] op_a, input logic [31:0] op_b);
		case (cnd)
			3'd0: return $signed(op_a) < $signed(op_b);
			3'd1: return $signed(op_a) >= $signed(op_b);
			3'd2: return op_a < op_b;
			3'd3: return op_a >= op_b;
			3'd4: return op_a[rb];
			3'd6: return op_a == op_b;
			3'd7: return op_a != op_b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic is_nan(input logic [31:0] x);
		return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
	endfunction

	// Maps a float onto an unsigned key that sorts in numeric order
	// Negative values are inverted so a larger magnitude gives a smaller key
	function automatic logic [31:0] order_key(input logic [31:0] x);
		return x[31] ? ~x : {1'b1, x[30:0]};
	endfunction

	function automatic logic fp_condition(input logic [2:0] cnd,
			input logic [31:0] op_a, input logic [31:0] op_b);
		logic unord;
		logic zeros;
		logic eq;
		logic lt;
		unord = is_nan(op_a) || is_nan(op_b);
		zeros = (op_a[30:0] == 31'h0) && (op_b[30:0] == 31'h0);
		eq    = !unord && (zeros || order_key(op_a) == order_key(op_b));
		lt    = !unord && !zeros && (order_key(op_a) < order_key(op_b));
		case (cnd)
			3'd0: return eq;
			3'd1: return !eq;
			3'd2: return lt;
			3'd3: return lt || eq;
			3'd6: return unord;
			3'd7: return !unord;
			default: return 1'b0;
		endcase
	endfunction

	// ==============================
	// Stimulus and result monitor
	// ==============================

	// Drives one beat and queues the result the pipeline should produce
	task automatic issue_beat(input logic [6:0] op, input logic [2:0] cnd,
			input logic [4:0] rb, input logic [16:0] disp, input logic [31:0] beat_pc,
			input logic [31:0] op_a, input logic [31:0] op_b, input logic pred);
		instruction_t        word;
		logic                exp_taken;
		logic [`BR_PC_W-1:0] exp_pc;
		word.opcode = opcode_t'(op);
		word.cnd    = cnd;
		word.rb     = rb;
		word.disp   = disp;
		if (op == OP_BCC) begin
			exp_taken = int_condition(cnd, rb, op_a, op_b);
		end else if (op == OP_FBCC) begin
			exp_taken = fp_condition(cnd, op_a, op_b);
		end else begin
			exp_taken = 1'b0;
		end
		if (exp_taken) begin
			exp_pc = beat_pc + {{(`BR_PC_W-17){disp[16]}}, disp} * `BR_INSN_BYTES;
		end else begin
			exp_pc = beat_pc + `BR_INSN_BYTES;
		end
		@(posedge clk);
		valid      <= 1'b1;
		ir         <= word;
		pc         <= beat_pc;
		a          <= op_a;
		b          <= op_b;
		pred_taken <= pred;
		expected_q.push_back({exp_taken, exp_taken ^ pred, exp_pc});
		// Driven at this edge, captured at the next, resolved at the one after
		due_q.push_back(live_edges + 3);
	endtask

	// Stops issuing and waits a bounded time for every queued result
	task automatic drain_pipe();
		int waited;
		waited = 0;
		@(posedge clk);
		valid <= 1'b0;
		while (expected_q.size() != 0 && waited < 6) begin
			@(posedge clk);
			waited++;
		end
		if (expected_q.size() != 0) begin
			error_count++;
			$display("ERROR: %0d results never left the pipeline", expected_q.size());
			expected_q.delete();
			due_q.delete();
		end
	endtask

	// Edges at which the pipeline is out of reset and not held
	always @(posedge clk) begin
		if (rst_n && !hold) begin
			live_edges <= live_edges + 1;
		end
	end

	// A result is consumed at the edge where s2 moves on, so a held result counts once
	always @(negedge clk) begin
		if (rst_n) begin
			check_count++;
			if ($isunknown(resolve_valid)) begin
				error_count++;
				$display("ERROR: resolve_valid_o is unknown");
			end
			if (!resolve_valid && mispredict !== 1'b0) begin
				error_count++;
				$display("FAILED mispredict_o: got %h, expected %h", mispredict, 1'b0);
			end
			if (resolve_valid && !hold) begin
				if (expected_q.size() == 0) begin
					error_count++;
					$display("ERROR: a result came out with no beat outstanding");
				end else begin
					exp_result = expected_q.pop_front();
					exp_due    = due_q.pop_front();
					if (live_edges != exp_due) begin
						error_count++;
						$display("ERROR: result arrived %0d edges after issue instead of 2",
							live_edges - exp_due + 2);
					end
					if (taken !== exp_result[`BR_PC_W+1]) begin
						error_count++;
						$display("FAILED taken_o: got %h, expected %h",
							taken, exp_result[`BR_PC_W+1]);
					end
					if (mispredict !== exp_result[`BR_PC_W]) begin
						error_count++;
						$display("FAILED mispredict_o: got %h, expected %h",
							mispredict, exp_result[`BR_PC_W]);
					end
					if (redirect_pc !== exp_result[`BR_PC_W-1:0]) begin
						error_count++;
						$display("FAILED redirect_pc_o: got %h, expected %h",
							redirect_pc, exp_result[`BR_PC_W-1:0]);
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("ERROR: run stopped after %0d cycles, tests did not finish", cycle_count);
			$display("Checks run: %0d, errors: %0d", check_count, error_count);
			$display("Some tests failed");
			$finish;
		end
	end

	// ==============================
	// Tests
	// ==============================

	// Neither output may be high while no beat is resolving
	task automatic expect_idle();
		if (resolve_valid !== 1'b0) begin
			error_count++;
			$display("FAILED resolve_valid_o: got %h, expected %h", resolve_valid, 1'b0);
		end
		if (mispredict !== 1'b0) begin
			error_count++;
			$display("FAILED mispredict_o: got %h, expected %h", mispredict, 1'b0);
		end
	endtask

	task automatic check_reset();
		repeat (4) begin
			@(posedge clk);
			@(negedge clk);
			expect_idle();
		end
		// Fifth low edge samples the old value while the release is scheduled
		@(posedge clk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			expect_idle();
		end
	endtask

	task automatic int_conditions();
		logic [31:0] ra;
		logic [31:0] rb_word;
		logic [31:0] rpc;
		logic [31:0] rmix;
		for (int c = 0; c < 8; c++) begin
			repeat (4) begin
				ra      = next_random();
				rb_word = next_random();
				rpc     = next_random();
				rmix    = next_random();
				issue_beat(OP_BCC, 3'(c), rmix[4:0], rmix[21:5], rpc, ra, rb_word, rmix[31]);
			end
		end
		// Equal operands through every condition
		ra = next_random();
		for (int c = 0; c < 8; c++) begin
			issue_beat(OP_BCC, 3'(c), 5'd3, 17'h00010, 32'h0000_4000, ra, ra, c[0]);
		end
		// Signed and unsigned order disagree on this pair
		for (int c = 0; c < 4; c++) begin
			issue_beat(OP_BCC, 3'(c), 5'd0, 17'h1fff8, 32'h0000_8000,
				32'h7fff_ffff, 32'h8000_0000, c[1]);
			issue_beat(OP_BCC, 3'(c), 5'd0, 17'h00008, 32'h0000_8000,
				32'h8000_0000, 32'h7fff_ffff, !c[1]);
		end
		issue_beat(OP_BCC, 3'd4, 5'd0, 17'h00004, 32'h0000_1000, 32'h8000_0001, 0, 1'b0);
		issue_beat(OP_BCC, 3'd4, 5'd31, 17'h00004, 32'h0000_1000, 32'h8000_0001, 0, 1'b1);
		issue_beat(OP_BCC, 3'd4, 5'd0, 17'h00004, 32'h0000_1000, 32'h7fff_fffe, 0, 1'b1);
		issue_beat(OP_BCC, 3'd4, 5'd31, 17'h00004, 32'h0000_1000, 32'h7fff_fffe, 0, 1'b0);
		drain_pipe();
	endtask

	task automatic fp_conditions();
		logic [31:0] fa [0:11];
		logic [31:0] fb [0:11];
		logic [31:0] rmix;
		// 1.0, 2.0, -1.5, -2.0, signed zeros, +inf and quiet NaNs
		fa = '{32'h3f80_0000, 32'h4000_0000, 32'hbfc0_0000, 32'h0000_0000,
			32'h8000_0000, 32'h7f80_0000, 32'h4000_0000, 32'h7fc0_0000,
			32'h3f80_0000, 32'h7fc0_0000, 32'h3f80_0000, 32'hbfc0_0000};
		fb = '{32'h4000_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h8000_0000,
			32'h0000_0000, 32'h4000_0000, 32'h7f80_0000, 32'h3f80_0000,
			32'hffc0_0001, 32'h7fc0_0000, 32'h3f80_0000, 32'hc000_0000};
		for (int p = 0; p < 12; p++) begin
			for (int c = 0; c < 8; c++) begin
				rmix = next_random();
				issue_beat(OP_FBCC, 3'(c), 5'd0, rmix[16:0], 32'h0002_0000,
					fa[p], fb[p], rmix[31]);
			end
		end
		drain_pipe();
	endtask

	task automatic non_branch_ops();
		logic [6:0] ops [0:3];
		ops = '{7'h00, 7'h13, 7'h2a, 7'h7f};
		for (int i = 0; i < 4; i++) begin
			issue_beat(ops[i], 3'd5, 5'd0, 17'h00100, 32'h0003_0000, 1, 1, 1'b0);
			// Bit test on a set bit would branch if decoded as a branch
			issue_beat(ops[i], 3'd4, 5'd0, 17'h00100, 32'h0003_0000, 1, 1, 1'b1);
		end
		drain_pipe();
	endtask

	task automatic target_addresses();
		logic [16:0] disps [0:5];
		disps = '{17'h00001, 17'h1ffff, 17'h0ffff, 17'h10000, 17'h00000, 17'h1fff0};
		// Equal operands with cnd 6 always take the branch
		for (int i = 0; i < 6; i++) begin
			issue_beat(OP_BCC, 3'd6, 5'd0, disps[i], 32'h0010_0000, 5, 5, i[0]);
		end
		drain_pipe();
	endtask

	task automatic hold_two_beats();
		logic [`BR_PC_W+2:0] snapshot;
		issue_beat(OP_BCC, 3'd0, 5'd0, 17'h00020, 32'h0000_2000, 1, 2, 1'b0);
		issue_beat(OP_BCC, 3'd7, 5'd0, 17'h1ffe0, 32'h0000_2004, 3, 3, 1'b1);
		@(posedge clk);
		valid <= 1'b0;
		hold  <= 1'b1;
		@(negedge clk);
		if (resolve_valid !== 1'b1) begin
			error_count++;
			$display("FAILED resolve_valid_o: got %h, expected %h", resolve_valid, 1'b1);
		end
		snapshot = {resolve_valid, taken, mispredict, redirect_pc};
		repeat (4) begin
			// These beats must be ignored while the pipe is held
			@(posedge clk);
			valid <= 1'b1;
			ir    <= next_random();
			a     <= next_random();
			@(negedge clk);
			if ({resolve_valid, taken, mispredict, redirect_pc} !== snapshot) begin
				error_count++;
				$display("FAILED {resolve_valid_o, taken_o, mispredict_o, redirect_pc_o}: "
					, "got %h, expected %h",
					{resolve_valid, taken, mispredict, redirect_pc}, snapshot);
			end
		end
		@(posedge clk);
		valid <= 1'b0;
		hold  <= 1'b0;
		drain_pipe();
	endtask

	initial begin
		rst_n      = 1'b0;
		hold       = 1'b0;
		valid      = 1'b0;
		ir         = '0;
		pc         = '0;
		a          = '0;
		b          = '0;
		pred_taken = 1'b0;
		check_reset();
		int_conditions();
		fp_conditions();
		non_branch_ops();
		target_addresses();
		hold_two_beats();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== branch_unit.f ====
+incdir+include
verilog/branch_pkg.sv
verilog/fp_compare.sv
verilog/branch_cond_eval.sv
verilog/branch_target_gen.sv
verilog/branch_ctrl.sv
verilog/branch_unit.sv
verif/branch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - include_dirs:
      - include
    files:
      - verilog/branch_pkg.sv
      - verilog/fp_compare.sv
      - verilog/branch_cond_eval.sv
      - verilog/branch_target_gen.sv
      - verilog/branch_ctrl.sv
      - verilog/branch_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/branch_unit_tb.sv
